// ==== src/icache_consts.svh ====
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// address split
`define ICACHE_TAG_W 20
`define ICACHE_INDEX_W 8
`define ICACHE_OFFSET_W 4

// organization
`define ICACHE_LINE_WORDS 4
`define ICACHE_WAYS 2

// bus read types
`define ICACHE_RD_WORD 3'b010
`define ICACHE_RD_LINE 3'b100

`endif

// ==== src/icache_addr_pkg.sv ====
`include "icache_consts.svh"

package icache_addr_pkg;

    // address fields
    typedef logic [`ICACHE_TAG_W-1:0] tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_OFFSET_W-1:0] offset_t;
    typedef logic [$clog2(`ICACHE_LINE_WORDS)-1:0] word_sel_t;
    typedef logic [`ICACHE_TAG_W+`ICACHE_INDEX_W+`ICACHE_OFFSET_W-1:0] addr_t;

    // payload
    typedef logic [31:0] word_t;
    typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;

endpackage

// ==== src/icache_ctrl_pkg.sv ====
`include "icache_consts.svh"

package icache_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } main_state_t;

    typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_id_t;

    // matches the width of the bus read-type codes
    typedef logic [2:0] rd_type_t;

endpackage

// ==== src/icache_ctrl.sv ====
`include "icache_consts.svh"

module icache_ctrl (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       valid,
    input  icache_addr_pkg::tag_t      tag,
    input  icache_addr_pkg::index_t    index,
    input  icache_addr_pkg::offset_t   offset,
    input  logic                       uncached,
    input  logic                       hit,
    input  logic                       rd_rdy,
    input  logic                       ret_valid,
    input  logic                       ret_last,
    input  icache_addr_pkg::word_t     ret_data,
    input  icache_addr_pkg::word_t     hit_word,
    input  icache_addr_pkg::word_t     miss_word,
    output logic                       addr_ok,
    output logic                       data_ok,
    output icache_addr_pkg::word_t     rdata,
    output logic                       accept,
    output icache_addr_pkg::tag_t      req_tag,
    output icache_addr_pkg::index_t    req_index,
    output icache_addr_pkg::word_sel_t req_word,
    output logic                       fill,
    output icache_ctrl_pkg::way_id_t   fill_way,
    output logic                       burst_start,
    output logic                       rd_req,
    output icache_ctrl_pkg::rd_type_t  rd_type,
    output icache_addr_pkg::addr_t     rd_addr
);

    icache_ctrl_pkg::main_state_t state;
    icache_addr_pkg::offset_t req_offset;
    icache_ctrl_pkg::way_id_t repl_ptr;
    logic req_uncached;
    logic addr_done;
    logic lookup_hit;
    logic last_beat;

    assign lookup_hit = (state == icache_ctrl_pkg::LOOKUP) & hit & !req_uncached;
    assign last_beat = (state == icache_ctrl_pkg::REFILL) & ret_valid & ret_last;

    // pipe side
    assign addr_ok = (state == icache_ctrl_pkg::IDLE) | lookup_hit;
    assign accept = valid & addr_ok;
    assign data_ok = lookup_hit | last_beat;
    assign rdata = (state == icache_ctrl_pkg::LOOKUP) ? hit_word :
                   req_uncached ? ret_data : miss_word;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= icache_ctrl_pkg::IDLE;
        end else begin
            case (state)
                icache_ctrl_pkg::IDLE: begin
                    if (accept) begin
                        state <= icache_ctrl_pkg::LOOKUP;
                    end
                end
                icache_ctrl_pkg::LOOKUP: begin
                    if (!lookup_hit) begin
                        state <= icache_ctrl_pkg::REFILL;
                    end else if (!accept) begin
                        state <= icache_ctrl_pkg::IDLE;
                    end
                end
                icache_ctrl_pkg::REFILL: begin
                    if (last_beat) begin
                        state <= icache_ctrl_pkg::IDLE;
                    end
                end
                default: state <= icache_ctrl_pkg::IDLE;
            endcase
        end
    end

    // request latch
    always_ff @(posedge clk) begin
        if (accept) begin
            req_tag <= tag;
            req_index <= index;
            req_offset <= offset;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            req_uncached <= 1'b0;
        end else if (accept) begin
            req_uncached <= uncached;
        end
    end

    assign req_word = req_offset[`ICACHE_OFFSET_W-1:2];

    // bus read, held until rd_rdy
    always_ff @(posedge clk) begin
        if (!resetn || state != icache_ctrl_pkg::REFILL) begin
            addr_done <= 1'b0;
        end else if (rd_req && rd_rdy) begin
            addr_done <= 1'b1;
        end
    end

    assign rd_req = (state == icache_ctrl_pkg::REFILL) & !addr_done;
    assign rd_type = req_uncached ? `ICACHE_RD_WORD : `ICACHE_RD_LINE;
    assign rd_addr = req_uncached ? {req_tag, req_index, req_offset} :
                     {req_tag, req_index, {`ICACHE_OFFSET_W{1'b0}}};
    assign burst_start = rd_req & rd_rdy & !req_uncached;

    // refill write and round-robin victim
    assign fill = last_beat & !req_uncached;
    assign fill_way = repl_ptr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            repl_ptr <= '0;
        end else if (fill) begin
            repl_ptr <= repl_ptr + 1'b1;
        end
    end

endmodule

// ==== src/icache_tag_array.sv ====
`include "icache_consts.svh"

module icache_tag_array (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     accept,
    input  icache_addr_pkg::index_t  index,
    input  icache_addr_pkg::tag_t    req_tag,
    input  icache_addr_pkg::index_t  req_index,
    input  logic                     fill,
    input  icache_ctrl_pkg::way_id_t fill_way,
    output logic                     hit,
    output icache_ctrl_pkg::way_id_t hit_way
);

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    logic [SETS-1:0] valid_bits [`ICACHE_WAYS];
    icache_addr_pkg::tag_t tags [`ICACHE_WAYS][SETS];
    logic [`ICACHE_WAYS-1:0] rd_valid;
    icache_addr_pkg::tag_t rd_tag [`ICACHE_WAYS];
    logic [`ICACHE_WAYS-1:0] way_hit;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_bits[w] <= '0;
            end
        end else if (fill) begin
            valid_bits[fill_way][req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            tags[fill_way][req_index] <= req_tag;
        end
    end

    // read both ways at acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                rd_valid[w] <= valid_bits[w][index];
                rd_tag[w] <= tags[w][index];
            end
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = rd_valid[w] & (rd_tag[w] == req_tag);
            if (way_hit[w]) begin
                hit_way = icache_ctrl_pkg::way_id_t'(w);
            end
        end
    end

    assign hit = |way_hit;

endmodule

// ==== src/icache_data_array.sv ====
`include "icache_consts.svh"

module icache_data_array (
    input  logic                       clk,
    input  logic                       accept,
    input  icache_addr_pkg::index_t    index,
    input  icache_ctrl_pkg::way_id_t   hit_way,
    input  icache_addr_pkg::word_sel_t req_word,
    input  logic                       fill,
    input  icache_ctrl_pkg::way_id_t   fill_way,
    input  icache_addr_pkg::index_t    req_index,
    input  icache_addr_pkg::line_t     fill_line,
    output icache_addr_pkg::word_t     hit_word
);

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    icache_addr_pkg::line_t lines [`ICACHE_WAYS][SETS];
    icache_addr_pkg::line_t rd_line [`ICACHE_WAYS];

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[fill_way][req_index] <= fill_line;
        end
    end

    // both ways registered, way picked after the tag compare
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                rd_line[w] <= lines[w][index];
            end
        end
    end

    assign hit_word = rd_line[hit_way][req_word*32 +: 32];

endmodule

// ==== src/icache_refill_buffer.sv ====
`include "icache_consts.svh"

module icache_refill_buffer (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       burst_start,
    input  logic                       ret_valid,
    input  icache_addr_pkg::word_t     ret_data,
    input  icache_addr_pkg::word_sel_t req_word,
    output icache_addr_pkg::line_t     fill_line,
    output icache_addr_pkg::word_t     miss_word
);

    icache_addr_pkg::word_sel_t beat_cnt;
    logic [`ICACHE_LINE_WORDS*32-1:0] line_q;

    // beats arrive word 0 first
    always_ff @(posedge clk) begin
        if (!resetn || burst_start) begin
            beat_cnt <= '0;
        end else if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (burst_start) begin
            line_q <= '0;
        end else if (ret_valid) begin
            line_q <= fill_line;
        end
    end

    // current beat merged in so the last beat can fill directly
    always_comb begin
        fill_line = line_q;
        if (ret_valid) begin
            fill_line[beat_cnt*32 +: 32] = ret_data;
        end
    end

    assign miss_word = fill_line[req_word*32 +: 32];

endmodule

// ==== src/icache.sv ====
`include "icache_consts.svh"

module icache (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      valid,
    input  icache_addr_pkg::tag_t     tag,
    input  icache_addr_pkg::index_t   index,
    input  icache_addr_pkg::offset_t  offset,
    input  logic                      uncached,
    output logic                      addr_ok,
    output logic                      data_ok,
    output icache_addr_pkg::word_t    rdata,
    output logic                      rd_req,
    output icache_ctrl_pkg::rd_type_t rd_type,
    output icache_addr_pkg::addr_t    rd_addr,
    input  logic                      rd_rdy,
    input  logic                      ret_valid,
    input  logic                      ret_last,
    input  icache_addr_pkg::word_t    ret_data
);

    logic accept;
    logic fill;
    logic burst_start;
    logic hit;
    icache_addr_pkg::tag_t req_tag;
    icache_addr_pkg::index_t req_index;
    icache_addr_pkg::word_sel_t req_word;
    icache_ctrl_pkg::way_id_t fill_way;
    icache_ctrl_pkg::way_id_t hit_way;
    icache_addr_pkg::word_t hit_word;
    icache_addr_pkg::word_t miss_word;
    icache_addr_pkg::line_t fill_line;

    icache_ctrl ctrl_i (
        .clk         (clk),
        .resetn      (resetn),
        .valid       (valid),
        .tag         (tag),
        .index       (index),
        .offset      (offset),
        .uncached    (uncached),
        .hit         (hit),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .ret_data    (ret_data),
        .hit_word    (hit_word),
        .miss_word   (miss_word),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rdata       (rdata),
        .accept      (accept),
        .req_tag     (req_tag),
        .req_index   (req_index),
        .req_word    (req_word),
        .fill        (fill),
        .fill_way    (fill_way),
        .burst_start (burst_start),
        .rd_req      (rd_req),
        .rd_type     (rd_type),
        .rd_addr     (rd_addr)
    );

    icache_tag_array tag_i (
        .clk       (clk),
        .resetn    (resetn),
        .accept    (accept),
        .index     (index),
        .req_tag   (req_tag),
        .req_index (req_index),
        .fill      (fill),
        .fill_way  (fill_way),
        .hit       (hit),
        .hit_way   (hit_way)
    );

    icache_data_array data_i (
        .clk       (clk),
        .accept    (accept),
        .index     (index),
        .hit_way   (hit_way),
        .req_word  (req_word),
        .fill      (fill),
        .fill_way  (fill_way),
        .req_index (req_index),
        .fill_line (fill_line),
        .hit_word  (hit_word)
    );

    icache_refill_buffer refill_i (
        .clk         (clk),
        .resetn      (resetn),
        .burst_start (burst_start),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .req_word    (req_word),
        .fill_line   (fill_line),
        .miss_word   (miss_word)
    );

endmodule

// ==== verification/icache_mem_model.sv ====
`include "icache_consts.svh"

module icache_mem_model (
    input  logic                      clk,
    input  logic                      rd_req,
    input  icache_ctrl_pkg::rd_type_t rd_type,
    input  icache_addr_pkg::addr_t    rd_addr,
    output logic                      rd_rdy,
    output logic                      ret_valid,
    output logic                      ret_last,
    output icache_addr_pkg::word_t    ret_data
);
    timeunit 1ns;
    timeprecision 1ns;

    integer seed;
    icache_ctrl_pkg::rd_type_t burst_type;
    icache_addr_pkg::addr_t burst_addr;
    int beats;

    // memory contents follow the word address
    function automatic icache_addr_pkg::word_t memory_word(icache_addr_pkg::addr_t a);
        return {a[31:2], 2'b00} ^ 32'ha5a5a5a5;
    endfunction

    task automatic wait_random_cycles();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(negedge clk);
    endtask

    initial begin
        seed = 32'hc079df52;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                wait_random_cycles();
                rd_rdy = 1'b1;
                burst_type = rd_type;
                burst_addr = rd_addr;
                @(negedge clk);
                rd_rdy = 1'b0;
                beats = (burst_type == `ICACHE_RD_LINE) ? `ICACHE_LINE_WORDS : 1;
                // beats in word order, with random gaps
                for (int b = 0; b < beats; b++) begin
                    wait_random_cycles();
                    ret_valid = 1'b1;
                    ret_last = (b == beats - 1);
                    ret_data = memory_word(burst_addr + 32'(b * 4));
                    @(negedge clk);
                    ret_valid = 1'b0;
                    ret_last = 1'b0;
                end
            end
        end
    end

endmodule

// ==== verification/icache_tb.sv ====
`include "icache_consts.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 1ns;

    typedef enum logic [1:0] {
        FETCH_NONE,
        FETCH_LINE,
        FETCH_WORD
    } fetch_kind_t;

    typedef struct packed {
        icache_addr_pkg::tag_t    tag;
        icache_addr_pkg::index_t  index;
        icache_addr_pkg::offset_t offset;
        logic                     uncached;
        fetch_kind_t              kind;
    } entry_t;

    localparam int NUM_ENTRIES = 16;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 30 + 100;

    logic clk;
    logic resetn;
    logic valid;
    icache_addr_pkg::tag_t tag;
    icache_addr_pkg::index_t index;
    icache_addr_pkg::offset_t offset;
    logic uncached;
    logic addr_ok;
    logic data_ok;
    icache_addr_pkg::word_t rdata;
    logic rd_req;
    icache_ctrl_pkg::rd_type_t rd_type;
    icache_addr_pkg::addr_t rd_addr;
    logic rd_rdy;
    logic ret_valid;
    logic ret_last;
    icache_addr_pkg::word_t ret_data;

    entry_t entries [NUM_ENTRIES];
    int accept_cycle [NUM_ENTRIES];
    int pending [$];
    int cur_entry;
    int cycles;
    int fetches;
    int done_count;
    logic accepted;

    icache dut_i (.*);

    icache_mem_model mem_i (.*);

    always #50 clk = ~clk;

    function automatic icache_addr_pkg::word_t memory_word(icache_addr_pkg::addr_t a);
        return {a[31:2], 2'b00} ^ 32'ha5a5a5a5;
    endfunction

    function automatic icache_addr_pkg::addr_t entry_addr(int e);
        return {entries[e].tag, entries[e].index, entries[e].offset};
    endfunction

    function automatic icache_ctrl_pkg::rd_type_t expected_type(int e);
        return (entries[e].kind == FETCH_WORD) ? `ICACHE_RD_WORD : `ICACHE_RD_LINE;
    endfunction

    // line reads go out line aligned
    function automatic icache_addr_pkg::addr_t expected_addr(int e);
        if (entries[e].kind == FETCH_WORD) begin
            return entry_addr(e);
        end
        return {entries[e].tag, entries[e].index, {`ICACHE_OFFSET_W{1'b0}}};
    endfunction

    task automatic stop_on_failure(string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(string msg);
        stop_on_failure($sformatf("ERROR at %0t: %s", $time, msg));
    endtask

    task automatic check_word(icache_addr_pkg::word_t got, icache_addr_pkg::word_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("rdata %h, expected %h", got, exp));
        end
    endtask

    task automatic check_fetch(icache_ctrl_pkg::rd_type_t got_type,
                               icache_addr_pkg::addr_t got_addr,
                               icache_ctrl_pkg::rd_type_t exp_type,
                               icache_addr_pkg::addr_t exp_addr);
        if (got_type !== exp_type || got_addr !== exp_addr) begin
            report_mismatch($sformatf("read type %b addr %h, expected type %b addr %h",
                                      got_type, got_addr, exp_type, exp_addr));
        end
    endtask

    task automatic check_state(logic got_addr_ok, logic got_data_ok, logic got_rd_req,
                               logic exp_addr_ok, logic exp_data_ok, logic exp_rd_req);
        if (got_addr_ok !== exp_addr_ok || got_data_ok !== exp_data_ok ||
            got_rd_req !== exp_rd_req) begin
            report_mismatch($sformatf("addr_ok/data_ok/rd_req %b%b%b, expected %b%b%b",
                                      got_addr_ok, got_data_ok, got_rd_req,
                                      exp_addr_ok, exp_data_ok, exp_rd_req));
        end
    endtask

    task automatic load_entries();
        // cold miss, then hits on the same line
        entries[0] = '{20'h12345, 8'h10, 4'h4, 1'b0, FETCH_LINE};
        entries[1] = '{20'h12345, 8'h10, 4'h0, 1'b0, FETCH_NONE};
        entries[2] = '{20'h12345, 8'h10, 4'h8, 1'b0, FETCH_NONE};
        entries[3] = '{20'h12345, 8'h10, 4'hc, 1'b0, FETCH_NONE};
        // second way of set 0x10, then a third tag evicts way 0
        entries[4] = '{20'h0abcd, 8'h10, 4'h0, 1'b0, FETCH_LINE};
        entries[5] = '{20'h12345, 8'h10, 4'h8, 1'b0, FETCH_NONE};
        entries[6] = '{20'h0abcd, 8'h10, 4'hc, 1'b0, FETCH_NONE};
        entries[7] = '{20'h77777, 8'h10, 4'h4, 1'b0, FETCH_LINE};
        entries[8] = '{20'h12345, 8'h10, 4'h0, 1'b0, FETCH_LINE};
        entries[9] = '{20'h77777, 8'h10, 4'h8, 1'b0, FETCH_NONE};
        // uncached reads bypass the arrays
        entries[10] = '{20'h77777, 8'h10, 4'h4, 1'b1, FETCH_WORD};
        entries[11] = '{20'h77777, 8'h10, 4'h4, 1'b0, FETCH_NONE};
        entries[12] = '{20'h00042, 8'h33, 4'hc, 1'b1, FETCH_WORD};
        entries[13] = '{20'h00042, 8'h33, 4'hc, 1'b0, FETCH_LINE};
        entries[14] = '{20'h00042, 8'h33, 4'h0, 1'b0, FETCH_NONE};
        entries[15] = '{20'h0abcd, 8'h10, 4'h4, 1'b0, FETCH_LINE};
    endtask

    // bus and response monitor
    always @(posedge clk) begin
        int e;
        if (resetn) begin
            cycles = cycles + 1;
            if (cycles > CYCLE_LIMIT) begin
                stop_on_failure($sformatf("timeout: table not finished within %0d cycles",
                                          CYCLE_LIMIT));
            end
            if (rd_req && rd_rdy) begin
                if (pending.size() == 0) begin
                    stop_on_failure("memory read issued with no request outstanding");
                end else if (entries[pending[0]].kind == FETCH_NONE) begin
                    report_mismatch($sformatf("entry %0d issued a read on a hit", pending[0]));
                end else begin
                    e = pending[0];
                    check_fetch(rd_type, rd_addr, expected_type(e), expected_addr(e));
                    fetches = fetches + 1;
                end
            end
            if (data_ok) begin
                if (pending.size() == 0) begin
                    stop_on_failure("data_ok with no request outstanding");
                end else begin
                    e = pending.pop_front();
                    check_word(rdata, memory_word(entry_addr(e)));
                    if (entries[e].kind == FETCH_NONE) begin
                        if (cycles != accept_cycle[e] + 1) begin
                            report_mismatch($sformatf("entry %0d hit answered after %0d cycles",
                                                      e, cycles - accept_cycle[e]));
                        end
                    end else if (fetches != 1) begin
                        report_mismatch($sformatf("entry %0d saw %0d reads, expected 1",
                                                  e, fetches));
                    end else if (!(ret_valid && ret_last)) begin
                        report_mismatch($sformatf("entry %0d answered outside the last beat",
                                                  e));
                    end
                    fetches = 0;
                    done_count = done_count + 1;
                end
            end
            if (valid && addr_ok) begin
                // after a hit the next request goes in on the following cycle
                if (cur_entry > 0 && entries[cur_entry - 1].kind == FETCH_NONE &&
                    cycles != accept_cycle[cur_entry - 1] + 1) begin
                    report_mismatch($sformatf("entry %0d accepted %0d cycles after a hit",
                                              cur_entry, cycles - accept_cycle[cur_entry - 1]));
                end
                pending.push_back(cur_entry);
                accept_cycle[cur_entry] = cycles;
                accepted = 1'b1;
            end
        end
    end

    initial begin
        clk = 1'b0;
        resetn = 1'b0;
        valid = 1'b0;
        tag = '0;
        index = '0;
        offset = '0;
        uncached = 1'b0;
        cycles = 0;
        fetches = 0;
        done_count = 0;
        cur_entry = 0;
        accepted = 1'b0;
        load_entries();
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        // idle after reset, and still quiet one cycle later
        @(posedge clk);
        check_state(addr_ok, data_ok, rd_req, 1'b1, 1'b0, 1'b0);
        @(posedge clk);
        check_state(addr_ok, data_ok, rd_req, 1'b1, 1'b0, 1'b0);
        @(negedge clk);
        // valid stays high so hits go back to back
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            cur_entry = i;
            accepted = 1'b0;
            valid = 1'b1;
            tag = entries[i].tag;
            index = entries[i].index;
            offset = entries[i].offset;
            uncached = entries[i].uncached;
            do begin
                @(negedge clk);
            end while (!accepted);
        end
        valid = 1'b0;
        while (done_count < NUM_ENTRIES) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+src
src/icache_addr_pkg.sv
src/icache_ctrl_pkg.sv
src/icache_ctrl.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_refill_buffer.sv
src/icache.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

// ==== Makefile ====
TOP = icache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ns -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "all tests passed" > /dev/null

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f sim.f --top-module icache

clean:
	rm -rf obj_dir
